/* rtl/vdpu_pkg.sv */
`default_nettype none

package vdpu_pkg;

   //////////////////////////////////////////////////////////////////////
   // Lane geometry
   localparam int VLANE_NUM      = 8;
   localparam int WORD_W         = 32;
   localparam int BYTES_PER_WORD = 4;
   localparam int LANE_IDX_W     = 3;   // Enough for VLANE_NUM lanes

   //////////////////////////////////////////////////////////////////////
   // Element width codes
   localparam int SEW_W = 2;
   localparam logic [SEW_W-1:0] SEW_8  = 2'd0;
   localparam logic [SEW_W-1:0] SEW_16 = 2'd1;
   localparam logic [SEW_W-1:0] SEW_32 = 2'd2;   // Code 3 is illegal

   // ALU operation codes
   localparam int ALU_OP_W = 3;
   localparam logic [ALU_OP_W-1:0] OP_ADD = 3'd0;
   localparam logic [ALU_OP_W-1:0] OP_SUB = 3'd1;
   localparam logic [ALU_OP_W-1:0] OP_AND = 3'd2;
   localparam logic [ALU_OP_W-1:0] OP_OR  = 3'd3;
   localparam logic [ALU_OP_W-1:0] OP_XOR = 3'd4;

   // Second operand select, code 3 left illegal
   localparam int OP2_SEL_W = 2;
   localparam logic [OP2_SEL_W-1:0] OP2_VEC = 2'd0;
   localparam logic [OP2_SEL_W-1:0] OP2_X   = 2'd1;
   localparam logic [OP2_SEL_W-1:0] OP2_IMM = 2'd2;

   localparam int IMM_W = 5;

   // Cycles through one lane_alu
   localparam int ALU_LAT = 1;

   //////////////////////////////////////////////////////////////////////
   // One lane word, seen whole, per byte or per halfword
   typedef union packed {
      logic [WORD_W-1:0]               word;
      logic [BYTES_PER_WORD-1:0][7:0]  bytes;
      logic [1:0][15:0]                halves;
   } lane_word_u;

endpackage

`default_nettype wire

/* rtl/operand_packer.sv */
`default_nettype none

module operand_packer
  (
   input  logic                                           clk_i,
   input  logic                                           rstn_i,
   input  logic                                           valid_i,
   input  logic                                           slide_i,
   input  logic [vdpu_pkg::ALU_OP_W-1:0]                  alu_op_i,
   input  logic [vdpu_pkg::SEW_W-1:0]                     sew_i,
   input  logic [vdpu_pkg::OP2_SEL_W-1:0]                 op2_sel_i,
   input  logic [vdpu_pkg::WORD_W-1:0]                    x_data_i,
   input  logic [vdpu_pkg::IMM_W-1:0]                     imm_i,
   input  vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0] vs1_i,
   input  vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0] vs2_i,
   output logic                                           alu_valid_o,
   output logic [vdpu_pkg::ALU_OP_W-1:0]                  alu_op_o,
   output logic [vdpu_pkg::SEW_W-1:0]                     sew_o,
   output logic [vdpu_pkg::VLANE_NUM-1:0][vdpu_pkg::WORD_W-1:0] op_a_o,
   output logic [vdpu_pkg::VLANE_NUM-1:0][vdpu_pkg::WORD_W-1:0] op_b_o
   );

   import vdpu_pkg::*;

   lane_word_u [VLANE_NUM-1:0] op_a, op_b;

   // Gathers the bytes of element k from the lanes it is striped over
   function automatic lane_word_u regroup(input lane_word_u [VLANE_NUM-1:0] v,
                                          input logic [SEW_W-1:0] sew,
                                          input int k);
      lane_word_u w;
      w.word = '0;
      case (sew)
         SEW_32:
         begin
            // Two elements per byte row, four lanes each
            for (int j = 0; j < BYTES_PER_WORD; j++)
               w.bytes[j] = v[BYTES_PER_WORD*(k % 2) + j].bytes[k / 2];
         end
         SEW_16:
         begin
            w.halves[0] = {v[2*(k % 4) + 1].bytes[k / 4], v[2*(k % 4)].bytes[k / 4]};
         end
         SEW_8:   w = v[k];   // Whole word, result byte 0 used later
         default: w.word = '0;
      endcase
      return w;
   endfunction

   always_comb
   begin
      for (int k = 0; k < VLANE_NUM; k++)
      begin
         op_a[k] = regroup(vs1_i, sew_i, k);
         case (op2_sel_i)
            OP2_VEC: op_b[k] = regroup(vs2_i, sew_i, k);
            OP2_X:   op_b[k] = x_data_i;                          // Scalar is not regrouped
            OP2_IMM: op_b[k] = {{(WORD_W-IMM_W){1'b0}}, imm_i};
            default: op_b[k] = '0;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
         alu_valid_o <= 1'b0;
      else
         alu_valid_o <= valid_i & ~slide_i;   // Slides bypass the ALUs
   end

   always_ff @(posedge clk_i)
   begin
      alu_op_o <= alu_op_i;
      sew_o    <= sew_i;
      for (int k = 0; k < VLANE_NUM; k++)
      begin
         op_a_o[k] <= op_a[k].word;
         op_b_o[k] <= op_b[k].word;
      end
   end

endmodule

`default_nettype wire

/* rtl/lane_alu.sv */
`default_nettype none

module lane_alu
  (
   input  logic                          clk_i,
   input  logic                          rstn_i,
   input  logic                          valid_i,
   input  logic [vdpu_pkg::ALU_OP_W-1:0] op_i,
   input  logic [vdpu_pkg::WORD_W-1:0]   a_i,
   input  logic [vdpu_pkg::WORD_W-1:0]   b_i,
   output logic [vdpu_pkg::WORD_W-1:0]   res_o,
   output logic                          valid_o
   );

   import vdpu_pkg::*;

   logic [WORD_W-1:0] res_d;

   // Full 32-bit op, narrower widths just keep the low bytes
   always_comb
   begin
      case (op_i)
         OP_ADD:  res_d = a_i + b_i;
         OP_SUB:  res_d = a_i - b_i;
         OP_AND:  res_d = a_i & b_i;
         OP_OR:   res_d = a_i | b_i;
         OP_XOR:  res_d = a_i ^ b_i;
         default: res_d = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
         valid_o <= 1'b0;
      else
         valid_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (valid_i)
         res_o <= res_d;   // Hold last result when idle
   end

endmodule

`default_nettype wire

/* rtl/slide_xbar.sv */
`default_nettype none

module slide_xbar
  (
   input  logic                                           clk_i,
   input  logic                                           rstn_i,
   input  logic                                           valid_i,
   input  logic                                           slide_i,
   input  logic                                           slide_up_i,
   input  logic [vdpu_pkg::LANE_IDX_W-1:0]                slide_amount_i,
   input  logic [1:0]                                     slide_byte_sel_i,
   input  vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0] vs2_i,
   output vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0] slide_res_o,
   output logic                                           slide_valid_o
   );

   import vdpu_pkg::*;

   logic [VLANE_NUM-1:0][LANE_IDX_W-1:0] src_lane;
   lane_word_u [VLANE_NUM-1:0]           slide_word;

   // Stage 0 matches the packer, the rest match the ALU
   lane_word_u [ALU_LAT:0][VLANE_NUM-1:0] res_pipe;
   logic [ALU_LAT:0]                      vld_pipe;

   always_comb
   begin
      for (int l = 0; l < VLANE_NUM; l++)
      begin
         // Lane index arithmetic wraps mod VLANE_NUM
         if (slide_up_i)
            src_lane[l] = LANE_IDX_W'(l) - slide_amount_i;
         else
            src_lane[l] = LANE_IDX_W'(l) + slide_amount_i;
         slide_word[l].word = {BYTES_PER_WORD{vs2_i[src_lane[l]].bytes[slide_byte_sel_i]}};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Delay line
   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
         vld_pipe <= '0;
      else
         vld_pipe <= {vld_pipe[ALU_LAT-1:0], valid_i & slide_i};
   end

   always_ff @(posedge clk_i)
   begin
      res_pipe[0] <= slide_word;
      for (int s = 1; s <= ALU_LAT; s++)
         res_pipe[s] <= res_pipe[s-1];
   end

   assign slide_res_o   = res_pipe[ALU_LAT];
   assign slide_valid_o = vld_pipe[ALU_LAT];

endmodule

`default_nettype wire

/* rtl/result_unpacker.sv */
`default_nettype none

module result_unpacker
  (
   input  logic                                                 clk_i,
   input  logic                                                 rstn_i,
   input  logic [vdpu_pkg::VLANE_NUM-1:0][vdpu_pkg::WORD_W-1:0] alu_res_i,
   input  logic                                                 alu_valid_i,
   input  logic [vdpu_pkg::SEW_W-1:0]                           sew_i,
   input  vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0]       slide_res_i,
   input  logic                                                 slide_valid_i,
   output vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0]       res_o,
   output logic                                                 res_valid_o
   );

   import vdpu_pkg::*;

   logic [SEW_W-1:0]           sew_q;   // Lines sew up with the ALU output
   lane_word_u [VLANE_NUM-1:0] alu_res;
   lane_word_u [VLANE_NUM-1:0] scattered;

   assign alu_res = alu_res_i;

   always_ff @(posedge clk_i)
   begin
      sew_q <= sew_i;
   end

   //////////////////////////////////////////////////////////////////////
   // Inverse of the packer layout, per output lane
   always_comb
   begin
      for (int l = 0; l < VLANE_NUM; l++)
      begin
         case (sew_q)
            SEW_32:
            begin
               for (int p = 0; p < BYTES_PER_WORD; p++)
                  scattered[l].bytes[p] = alu_res[2*p + l/BYTES_PER_WORD].bytes[l % BYTES_PER_WORD];
            end
            SEW_16:
            begin
               scattered[l].halves[0] = {alu_res[4 + l/2].bytes[l % 2], alu_res[l/2].bytes[l % 2]};
               scattered[l].halves[1] = scattered[l].halves[0];   // Duplicated halfword
            end
            SEW_8:   scattered[l].word = {BYTES_PER_WORD{alu_res[l].bytes[0]}};
            default: scattered[l].word = '0;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
         res_valid_o <= 1'b0;
      else
         res_valid_o <= alu_valid_i | slide_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (slide_valid_i)
         res_o <= slide_res_i;
      else
         res_o <= scattered;
   end

endmodule

`default_nettype wire

/* rtl/vdpu_top.sv */
`default_nettype none

module vdpu_top
  (
   input  logic                                           clk_i,
   input  logic                                           rstn_i,
   input  logic                                           valid_i,
   input  logic                                           slide_i,
   input  logic [vdpu_pkg::ALU_OP_W-1:0]                  alu_op_i,
   input  logic [vdpu_pkg::SEW_W-1:0]                     sew_i,
   input  logic [vdpu_pkg::OP2_SEL_W-1:0]                 op2_sel_i,
   input  logic [vdpu_pkg::WORD_W-1:0]                    x_data_i,
   input  logic [vdpu_pkg::IMM_W-1:0]                     imm_i,
   input  logic                                           slide_up_i,
   input  logic [vdpu_pkg::LANE_IDX_W-1:0]                slide_amount_i,
   input  logic [1:0]                                     slide_byte_sel_i,
   input  vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0] vs1_i,
   input  vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0] vs2_i,
   output vdpu_pkg::lane_word_u [vdpu_pkg::VLANE_NUM-1:0] res_o,
   output logic                                           res_valid_o
   );

   import vdpu_pkg::*;

   // Packer to ALUs
   logic                                alu_valid;
   logic [ALU_OP_W-1:0]                 alu_op;
   logic [SEW_W-1:0]                    alu_sew;   // Follows the op to the unpacker
   logic [VLANE_NUM-1:0][WORD_W-1:0]    op_a, op_b;

   // ALUs to unpacker
   logic [VLANE_NUM-1:0][WORD_W-1:0]    alu_res;
   logic [VLANE_NUM-1:0]                alu_res_vld;

   lane_word_u [VLANE_NUM-1:0]          slide_res;
   logic                                slide_valid;

   operand_packer u_packer
     (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .valid_i     (valid_i),
      .slide_i     (slide_i),
      .alu_op_i    (alu_op_i),
      .sew_i       (sew_i),
      .op2_sel_i   (op2_sel_i),
      .x_data_i    (x_data_i),
      .imm_i       (imm_i),
      .vs1_i       (vs1_i),
      .vs2_i       (vs2_i),
      .alu_valid_o (alu_valid),
      .alu_op_o    (alu_op),
      .sew_o       (alu_sew),
      .op_a_o      (op_a),
      .op_b_o      (op_b)
      );

   for (genvar i = 0; i < VLANE_NUM; i++)
   begin : gen_alu
      lane_alu u_alu
        (
         .clk_i   (clk_i),
         .rstn_i  (rstn_i),
         .valid_i (alu_valid),
         .op_i    (alu_op),
         .a_i     (op_a[i]),
         .b_i     (op_b[i]),
         .res_o   (alu_res[i]),
         .valid_o (alu_res_vld[i])
         );
   end

   slide_xbar u_xbar
     (
      .clk_i            (clk_i),
      .rstn_i           (rstn_i),
      .valid_i          (valid_i),
      .slide_i          (slide_i),
      .slide_up_i       (slide_up_i),
      .slide_amount_i   (slide_amount_i),
      .slide_byte_sel_i (slide_byte_sel_i),
      .vs2_i            (vs2_i),
      .slide_res_o      (slide_res),
      .slide_valid_o    (slide_valid)
      );

   result_unpacker u_unpacker
     (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .alu_res_i     (alu_res),
      .alu_valid_i   (&alu_res_vld),   // All lanes step together
      .sew_i         (alu_sew),
      .slide_res_i   (slide_res),
      .slide_valid_i (slide_valid),
      .res_o         (res_o),
      .res_valid_o   (res_valid_o)
      );

endmodule

`default_nettype wire

/* testbench/vdpu_asserts.sv */
`default_nettype none

module vdpu_asserts
  (
   input logic                           clk_i,
   input logic                           rstn_i,
   input logic                           valid_i,
   input logic [vdpu_pkg::SEW_W-1:0]     sew_i,
   input logic [vdpu_pkg::OP2_SEL_W-1:0] op2_sel_i,
   input logic                           res_valid_o
   );

   timeunit 1ns;
   timeprecision 100ps;

   import vdpu_pkg::*;

   localparam int PIPE_LAT = 3;   // Packer, ALU, unpacker

   //////////////////////////////////////////////////////////////////////
   // Legal codes on a strobe
   legal_sew: assert property (@(posedge clk_i) disable iff (!rstn_i)
                               valid_i |-> sew_i <= SEW_32)
      else $error("sew_i carries the illegal code 3");

   legal_op2_sel: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                   valid_i |-> op2_sel_i <= OP2_IMM)
      else $error("op2_sel_i carries the illegal code 3");

   // Fixed latency both ways
   valid_to_res: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                  valid_i |-> ##PIPE_LAT res_valid_o)
      else $error("res_valid_o missing three cycles after valid_i");

   res_from_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                    res_valid_o |-> $past(valid_i, PIPE_LAT))
      else $error("res_valid_o high without valid_i three cycles earlier");

   quiet_after_reset: assert property (@(posedge clk_i) !rstn_i |=> !res_valid_o)
      else $error("res_valid_o high in the cycle after reset");

endmodule

`default_nettype wire

/* testbench/vdpu_tb.sv */
`default_nettype none

module vdpu_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import vdpu_pkg::*;

   localparam int GAP_CYCLES  = 4;
   localparam int MIX_SLOTS   = 48;
   // Regroup, operand select, logic, slide and mixed groups, each followed by a gap
   localparam int NUM_SLOTS   = 24 + 30 + 18 + 64 + MIX_SLOTS + 5*GAP_CYCLES;
   localparam int RESET_CYC   = 2;
   localparam int LATENCY     = 3;
   localparam int CYCLE_LIMIT = NUM_SLOTS + RESET_CYC + LATENCY + 20;

   logic                       clk_i;
   logic                       rstn_i;
   logic                       valid_i;
   logic                       slide_i;
   logic [ALU_OP_W-1:0]        alu_op_i;
   logic [SEW_W-1:0]           sew_i;
   logic [OP2_SEL_W-1:0]       op2_sel_i;
   logic [WORD_W-1:0]          x_data_i;
   logic [IMM_W-1:0]           imm_i;
   logic                       slide_up_i;
   logic [LANE_IDX_W-1:0]      slide_amount_i;
   logic [1:0]                 slide_byte_sel_i;
   lane_word_u [VLANE_NUM-1:0] vs1_i;
   lane_word_u [VLANE_NUM-1:0] vs2_i;
   lane_word_u [VLANE_NUM-1:0] res_o;
   logic                       res_valid_o;

   logic [VLANE_NUM-1:0][WORD_W-1:0] exp_q[$];   // Expected lane words
   int                               cyc_q[$];   // Cycle of each strobe
   string                            name_q[$];

   logic [31:0] lfsr   = 32'h30ca1f4f;
   int          cycle  = 0;
   int          errors = 0;
   int          checks = 0;

   vdpu_top dut
     (
      .clk_i            (clk_i),
      .rstn_i           (rstn_i),
      .valid_i          (valid_i),
      .slide_i          (slide_i),
      .alu_op_i         (alu_op_i),
      .sew_i            (sew_i),
      .op2_sel_i        (op2_sel_i),
      .x_data_i         (x_data_i),
      .imm_i            (imm_i),
      .slide_up_i       (slide_up_i),
      .slide_amount_i   (slide_amount_i),
      .slide_byte_sel_i (slide_byte_sel_i),
      .vs1_i            (vs1_i),
      .vs2_i            (vs2_i),
      .res_o            (res_o),
      .res_valid_o      (res_valid_o)
      );

   bind vdpu_top vdpu_asserts u_asserts
     (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .valid_i     (valid_i),
      .sew_i       (sew_i),
      .op2_sel_i   (op2_sel_i),
      .res_valid_o (res_valid_o)
      );

   //////////////////////////////////////////////////////////////////////
   // Random source and reference model
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
   endfunction

   function automatic logic [31:0] next_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Lane holding byte j of element k
   function automatic int elem_lane(input logic [SEW_W-1:0] sew, input int k, input int j);
      if (sew == SEW_32)
         return 4*(k % 2) + j;
      else if (sew == SEW_16)
         return 2*(k % 4) + j;
      return k;
   endfunction

   function automatic int elem_pos(input logic [SEW_W-1:0] sew, input int k);
      if (sew == SEW_32)
         return k / 2;
      else if (sew == SEW_16)
         return k / 4;
      return 0;
   endfunction

   function automatic logic [VLANE_NUM-1:0][WORD_W-1:0] predict_result(
      input logic                             slide,
      input logic [ALU_OP_W-1:0]              op,
      input logic [SEW_W-1:0]                 sew,
      input logic [OP2_SEL_W-1:0]             sel,
      input logic [WORD_W-1:0]                x,
      input logic [IMM_W-1:0]                 imm,
      input logic                             up,
      input logic [LANE_IDX_W-1:0]            amt,
      input logic [1:0]                       bsel,
      input logic [VLANE_NUM-1:0][WORD_W-1:0] v1,
      input logic [VLANE_NUM-1:0][WORD_W-1:0] v2);
      logic [VLANE_NUM-1:0][WORD_W-1:0] res;
      logic [WORD_W-1:0]                a;
      logic [WORD_W-1:0]                b;
      logic [WORD_W-1:0]                r;
      int                               nbytes;
      int                               src;
      res = '0;
      if (slide)
      begin
         for (int l = 0; l < VLANE_NUM; l++)
         begin
            src    = up ? (l + VLANE_NUM - amt) % VLANE_NUM : (l + amt) % VLANE_NUM;
            res[l] = {4{v2[src][8*bsel +: 8]}};
         end
         return res;
      end
      nbytes = (sew == SEW_32) ? 4 : ((sew == SEW_16) ? 2 : 1);
      for (int k = 0; k < VLANE_NUM; k++)
      begin
         a = '0;
         b = '0;
         for (int j = 0; j < nbytes; j++)
         begin
            a[8*j +: 8] = v1[elem_lane(sew, k, j)][8*elem_pos(sew, k) +: 8];
            b[8*j +: 8] = v2[elem_lane(sew, k, j)][8*elem_pos(sew, k) +: 8];
         end
         if (sel == OP2_X)
            b = x;
         else if (sel == OP2_IMM)
            b = {{(WORD_W-IMM_W){1'b0}}, imm};
         case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            default: r = a ^ b;
         endcase
         for (int j = 0; j < nbytes; j++)
            res[elem_lane(sew, k, j)][8*elem_pos(sew, k) +: 8] = r[8*j +: 8];
      end
      for (int l = 0; l < VLANE_NUM; l++)
      begin
         if (sew == SEW_16)
            res[l][31:16] = res[l][15:0];
         else if (sew == SEW_8)
            res[l] = {4{res[l][7:0]}};
      end
      return res;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   task automatic drive_op(input logic slide, input int op, input int sew, input int sel,
                           input int up, input int amt, input int bsel, input string name);
      @(negedge clk_i);
      valid_i          = 1'b1;
      slide_i          = slide;
      alu_op_i         = ALU_OP_W'(op);
      sew_i            = SEW_W'(sew);
      op2_sel_i        = OP2_SEL_W'(sel);
      slide_up_i       = up[0];
      slide_amount_i   = LANE_IDX_W'(amt);
      slide_byte_sel_i = 2'(bsel);
      for (int l = 0; l < VLANE_NUM; l++)
      begin
         vs1_i[l].word = next_bits(32);
         vs2_i[l].word = next_bits(32);
      end
      x_data_i = next_bits(32);
      imm_i    = IMM_W'(next_bits(IMM_W));
      exp_q.push_back(predict_result(slide_i, alu_op_i, sew_i, op2_sel_i, x_data_i, imm_i,
                                     slide_up_i, slide_amount_i, slide_byte_sel_i,
                                     vs1_i, vs2_i));
      cyc_q.push_back(cycle);
      name_q.push_back(name);
   endtask

   task automatic alu_request(input int op, input int sew, input int sel);
      drive_op(1'b0, op, sew, sel, 0, 0, 0, $sformatf("op%0d sew%0d sel%0d", op, sew, sel));
   endtask

   task automatic slide_request(input int up, input int amt, input int bsel);
      drive_op(1'b1, OP_ADD, SEW_8, OP2_VEC, up, amt, bsel,
               $sformatf("slide up%0d amt%0d byte%0d", up, amt, bsel));
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(negedge clk_i);
         valid_i = 1'b0;
      end
   endtask

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   initial
   begin
      int pick;
      int arg_a;
      int arg_b;
      int arg_c;
      rstn_i           = 1'b0;
      valid_i          = 1'b0;
      slide_i          = 1'b0;
      alu_op_i         = OP_ADD;
      sew_i            = SEW_8;
      op2_sel_i        = OP2_VEC;
      x_data_i         = '0;
      imm_i            = '0;
      slide_up_i       = 1'b0;
      slide_amount_i   = '0;
      slide_byte_sel_i = '0;
      vs1_i            = '0;
      vs2_i            = '0;
      repeat (RESET_CYC) @(posedge clk_i);
      @(negedge clk_i);
      rstn_i = 1'b1;

      for (int s = 0; s < 3; s++)   // Vector add and subtract per width
         for (int o = 0; o < 2; o++)
            for (int r = 0; r < 4; r++)
               alu_request(o, s, OP2_VEC);
      idle_cycles(GAP_CYCLES);

      for (int o = 0; o < 5; o++)   // Scalar and immediate
         for (int s = 0; s < 3; s++)
         begin
            alu_request(o, s, OP2_X);
            alu_request(o, s, OP2_IMM);
         end
      idle_cycles(GAP_CYCLES);

      for (int o = OP_AND; o <= OP_XOR; o++)
         for (int s = 0; s < 3; s++)
            for (int r = 0; r < 2; r++)
               alu_request(o, s, OP2_VEC);
      idle_cycles(GAP_CYCLES);

      for (int u = 0; u < 2; u++)
         for (int a = 0; a < VLANE_NUM; a++)
            for (int b = 0; b < BYTES_PER_WORD; b++)
               slide_request(u, a, b);
      idle_cycles(GAP_CYCLES);

      // Mixed traffic with occasional idle slots
      for (int i = 0; i < MIX_SLOTS; i++)
      begin
         pick = next_bits(2);
         if (pick == 0)
            idle_cycles(1);
         else if (pick == 1)
         begin
            arg_a = next_bits(1);
            arg_b = next_bits(3);
            arg_c = next_bits(2);
            slide_request(arg_a, arg_b, arg_c);
         end
         else
         begin
            arg_a = next_bits(3) % 5;
            arg_b = next_bits(2) % 3;
            arg_c = next_bits(2) % 3;
            alu_request(arg_a, arg_b, arg_c);
         end
      end
      idle_cycles(GAP_CYCLES);

      while (exp_q.size() != 0)
         @(negedge clk_i);
      repeat (2) @(negedge clk_i);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Scoreboard
   always @(negedge clk_i)
   begin : scoreboard
      logic [VLANE_NUM-1:0][WORD_W-1:0] expected;
      string                            name;
      int                               issued;
      if (rstn_i && res_valid_o)
      begin
         checks++;
         assert (exp_q.size() != 0)
         else
         begin
            errors++;
            $display("Result appeared at cycle %0d with no operation outstanding", cycle);
         end
         if (exp_q.size() != 0)
         begin
            expected = exp_q.pop_front();
            issued   = cyc_q.pop_front();
            name     = name_q.pop_front();
            checks++;
            assert (cycle - issued == LATENCY)
            else
            begin
               errors++;
               $display("Result of %s came %0d cycles after its strobe instead of %0d",
                        name, cycle - issued, LATENCY);
            end
            for (int l = 0; l < VLANE_NUM; l++)
            begin
               checks++;
               assert (res_o[l].word === expected[l])
               else
               begin
                  errors++;
                  $display("[FAIL] %s lane %0d: expected %08h, actual %08h",
                           name, l, expected[l], res_o[l].word);
               end
            end
         end
      end
      else if (rstn_i && exp_q.size() != 0)
      begin
         checks++;
         assert (cycle - cyc_q[0] < LATENCY)
         else
         begin
            errors++;
            $display("No result for %s %0d cycles after its strobe", name_q[0],
                     cycle - cyc_q[0]);
            void'(exp_q.pop_front());   // Drop it so later results still line up
            void'(cyc_q.pop_front());
            void'(name_q.pop_front());
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycle <= cycle + 1;
      if (cycle >= CYCLE_LIMIT)
      begin
         $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
         $display("tests failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* vdpu.f */
rtl/vdpu_pkg.sv
rtl/operand_packer.sv
rtl/lane_alu.sv
rtl/slide_xbar.sv
rtl/result_unpacker.sv
rtl/vdpu_top.sv
testbench/vdpu_asserts.sv
testbench/vdpu_tb.sv

/* Makefile */
TOP := vdpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vdpu.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vdpu.f

clean:
	rm -rf obj_dir sim.log
